// ==== bench/syncGen_assert.sv ====
// sync generator assertions
module syncGenAssert (
  input logic           clk,
  input logic           reset,
  input videoPkg::syncT timing
);
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // flag relations
  // --------------------------------------------------
  // frame end is always a line end
  eofWithEol: assert property (@(posedge clk) disable iff (reset)
    timing.eof |-> timing.eol)
    else $error("eof flagged without eol");

  vSyncBlanked: assert property (@(posedge clk) disable iff (reset)
    timing.vSync |-> timing.blank)
    else $error("vSync outside blanking");

  hSyncBlanked: assert property (@(posedge clk) disable iff (reset)
    !timing.hSync |-> timing.blank)  // active low
    else $error("hSync outside blanking");

  // blank window sits inside border window
  blankInBorder: assert property (@(posedge clk) disable iff (reset)
    timing.blank |-> timing.border)
    else $error("blank set while border clear");

  eolSingle: assert property (@(posedge clk) disable iff (reset)
    timing.eol |=> !timing.eol)
    else $error("eol held longer than one clock");

endmodule

bind syncGen syncGenAssert syncCheck (
  .clk    (clk),
  .reset  (reset),
  .timing (timing)
);

// ==== bench/videoTb.sv ====
// video timing testbench
module videoTb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [videoPkg::ctrWidth-1:0] posT;

  // --------------------------------------------------
  // small test timing of 40 x 20 clocks per frame
  // --------------------------------------------------
  localparam posT hSyncOn     = 12'd2;
  localparam posT hSyncOff    = 12'd5;
  localparam posT hBlankOff   = 12'd8;
  localparam posT hBorderOff  = 12'd10;  // display 10..33
  localparam posT hBorderOn   = 12'd34;
  localparam posT hBlankOn    = 12'd36;
  localparam posT hTotal      = 12'd40;
  localparam posT vSyncOn     = 12'd1;
  localparam posT vSyncOff    = 12'd3;
  localparam posT vBlankOff   = 12'd4;
  localparam posT vBorderOff  = 12'd6;   // display lines 6..17
  localparam posT vBorderOn   = 12'd18;
  localparam posT vBlankOn    = 12'd20;
  localparam posT vTotal      = 12'd20;
  localparam posT barWidth    = 12'd3;   // 8 bars over 24 pixels
  localparam int  gridShift   = 2;
  localparam posT gridPitch   = posT'(1 << gridShift);
  localparam int  frameCycles = int'(hTotal) * int'(vTotal);
  localparam int  numRows     = 6;

  typedef struct packed {
    videoPkg::patternE mode;
    videoPkg::rgbT     fg;
    videoPkg::rgbT     border;
  } settingsT;

  typedef struct packed {
    settingsT   set;
    logic [3:0] frames; // frames to run once applied
  } stimRowT;

  logic              clk = 1'b0;
  logic              reset;
  videoPkg::patternE mode;
  videoPkg::rgbT     fgColor;
  videoPkg::rgbT     borderColor;
  videoPkg::syncT    sync;
  videoPkg::rgbT     pixel;

  stimRowT     stimTable [numRows];
  logic [31:0] lcgState;
  longint      watchdogNs = 0;
  settingsT    inPrev;         // inputs seen one cycle back
  settingsT    active;         // settings of the frame on the output
  posT         hPos = 12'd1;   // model position of the output
  posT         vPos = 12'd1;
  logic        synced = 1'b0;  // set by first eof

  always #10 clk = ~clk;

  videoTop #(
    .hSyncOn (hSyncOn), .hSyncOff (hSyncOff), .hBlankOff (hBlankOff),
    .hBorderOff (hBorderOff), .hBorderOn (hBorderOn), .hBlankOn (hBlankOn),
    .hTotal (hTotal),
    .vSyncOn (vSyncOn), .vSyncOff (vSyncOff), .vBlankOff (vBlankOff),
    .vBorderOff (vBorderOff), .vBorderOn (vBorderOn), .vBlankOn (vBlankOn),
    .vTotal (vTotal),
    .barWidth (barWidth), .gridShift (gridShift)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .fgColor     (fgColor),
    .borderColor (borderColor),
    .sync        (sync),
    .pixel       (pixel)
  );

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic isBlank(input posT h, input posT v);
    return (h < hBlankOff) || (h >= hBlankOn) || (v < vBlankOff) || (v >= vBlankOn);
  endfunction

  function automatic logic isBorder(input posT h, input posT v);
    return (h < hBorderOff) || (h >= hBorderOn) || (v < vBorderOff) || (v >= vBorderOn);
  endfunction

  function automatic videoPkg::syncT expectedSync(input posT h, input posT v);
    videoPkg::syncT s;
    s.hSync  = !((h >= hSyncOn) && (h < hSyncOff)); // low in window
    s.vSync  = (v >= vSyncOn) && (v < vSyncOff);
    s.blank  = isBlank(h, v);
    s.border = isBorder(h, v);
    s.eol    = (h == hTotal);
    s.eof    = (h == hTotal) && (v == vTotal);
    return s;
  endfunction

  function automatic videoPkg::rgbT expectedPixel(input posT h, input posT v,
                                                  input settingsT s);
    videoPkg::rgbT p;
    posT x;
    posT y;
    posT bar;
    x   = h - hBorderOff; // only meaningful inside display
    y   = v - vBorderOff;
    bar = x / barWidth;
    p   = '0;
    if (isBlank(h, v)) begin
      p = '0;
    end else if (isBorder(h, v)) begin
      p = s.border;
    end else begin
      case (s.mode)
        videoPkg::patSolid: p = s.fg;
        videoPkg::patBars: begin
          p.red   = {4{bar[2]}};
          p.green = {4{bar[1]}};
          p.blue  = {4{bar[0]}};
        end
        videoPkg::patGrid: begin
          if (((x % gridPitch) == '0) || ((y % gridPitch) == '0))
            p = 12'hfff;   // grid line
        end
        default: p = '0;
      endcase
    end
    return p;
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic checkSync(input videoPkg::syncT expected, input videoPkg::syncT actual);
    if (actual !== expected) begin
      $display("Error: sync expected %h got %h at %0t", expected, actual, $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "sync mismatch");
    end
  endtask

  task automatic checkPixel(input videoPkg::rgbT expected, input videoPkg::rgbT actual);
    if (actual !== expected) begin
      $display("Error: pixel expected %h got %h at %0t", expected, actual, $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "pixel mismatch");
    end
  endtask

  // outputs are compared mid cycle
  always @(negedge clk) begin
    if (!reset && synced) begin
      checkSync(expectedSync(hPos, vPos), sync);
      checkPixel(expectedPixel(hPos, vPos, active), pixel);
      if (hPos == hTotal) begin
        hPos = 12'd1;
        vPos = (vPos == vTotal) ? 12'd1 : vPos + 12'd1;
      end else begin
        hPos = hPos + 12'd1;
      end
    end
    if (!reset && sync.eof === 1'b1) begin
      synced = 1'b1;
      hPos   = 12'd1;   // next output is first pixel
      vPos   = 12'd1;
      active = inPrev;  // settings held at the eof edge
    end
    inPrev = '{mode, fgColor, borderColor};
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic stimRowT makeRow(input videoPkg::patternE m, input videoPkg::rgbT fg,
                                      input videoPkg::rgbT bd, input logic [3:0] n);
    stimRowT r;
    r.set.mode   = m;
    r.set.fg     = fg;
    r.set.border = bd;
    r.frames     = n;
    return r;
  endfunction

  task automatic waitEof();
    do @(negedge clk); while (sync.eof !== 1'b1);
  endtask

  initial begin
    longint frameSum;
    int     offset;
    mode        <= videoPkg::patSolid;
    fgColor     <= '0;
    borderColor <= '0;
    reset       <= 1'b1;
    lcgState = 32'd40602;
    stimTable[0] = makeRow(videoPkg::patSolid, 12'ha53, 12'h15c, 4'd2);
    stimTable[1] = makeRow(videoPkg::patBars,  12'h000, 12'hf80, 4'd2);
    stimTable[2] = makeRow(videoPkg::patGrid,  12'h3c3, 12'h0ff, 4'd2);
    stimTable[3] = makeRow(videoPkg::patSolid, 12'h0f0, 12'hf00, 4'd1);
    stimTable[4] = makeRow(videoPkg::patGrid,  12'hfff, 12'h888, 4'd1);
    stimTable[5] = makeRow(videoPkg::patBars,  12'h123, 12'h4a7, 4'd1);
    frameSum = 0;
    for (int i = 0; i < numRows; i++)
      frameSum = frameSum + longint'(stimTable[i].frames);
    // each row costs up to two frames more than its count
    watchdogNs = (frameSum + 2 * numRows + 4) * frameCycles * 20 + 2000;

    repeat (3) @(posedge clk);
    @(negedge clk);
    checkSync('{hSync: 1'b1, vSync: 1'b0, blank: 1'b1, border: 1'b1,
                eol: 1'b0, eof: 1'b0}, sync);
    checkPixel('0, pixel);
    @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < numRows; i++) begin
      waitEof();
      lcgState = lcgNext(lcgState);
      offset   = 1 + int'(lcgState[23:8]) % (frameCycles - 1); // mid frame
      repeat (offset) @(posedge clk);
      mode        <= stimTable[i].set.mode;
      fgColor     <= stimTable[i].set.fg;
      borderColor <= stimTable[i].set.border;
      repeat (stimTable[i].frames) waitEof();
    end
    repeat (2) waitEof(); // last row fully shown
    @(posedge clk);

    $display("*** TEST PASSED ***");
    $finish;
  end

  // watchdog
  initial begin
    wait (watchdogNs != 0);
    #(watchdogNs);
    $display("timeout, the frames did not complete in the expected time");
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== filelist.f ====
src/videoPkg.sv
src/posCounter.sv
src/syncGen.sv
src/patternGen.sv
src/videoTop.sv
bench/syncGen_assert.sv
bench/videoTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module videoTb --Mdir "$BUILD" -o videoSim -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD/videoSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// ==== src/patternGen.sv ====
// test pattern generator
module patternGen #(
  parameter logic [videoPkg::ctrWidth-1:0] barWidth  = 12'd105, // pixels per bar
  parameter int                            gridShift = 4        // grid pitch 2**gridShift
) (
  input  logic            clk,
  input  logic            reset,
  input  videoPkg::syncT  timing,      // from syncGen
  input  videoPkg::patternE mode,
  input  videoPkg::rgbT   fgColor,
  input  videoPkg::rgbT   borderColor,
  output videoPkg::syncT  sync,        // timing delayed to match pixel
  output videoPkg::rgbT   pixel
);

  localparam logic [videoPkg::ctrWidth-1:0] gridMask =
    videoPkg::ctrWidth'((1 << gridShift) - 1);

  // settings held for a whole frame
  videoPkg::patternE frameMode;
  videoPkg::rgbT     frameFg;
  videoPkg::rgbT     frameBorder;

  logic [videoPkg::ctrWidth-1:0] xPos;   // display x, 0 at first display pixel
  logic [videoPkg::ctrWidth-1:0] yPos;   // display y
  logic [videoPkg::ctrWidth-1:0] barCnt; // pixel within current bar
  logic [2:0]                    barIdx;
  logic                          borderQ; // border of previous pixel
  logic                          inDisplay;
  videoPkg::rgbT                 nextPixel;

  assign inDisplay = ~timing.border;

  // --------------------------------------------------
  // frame latched settings
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      frameMode   <= videoPkg::patSolid;
      frameFg     <= videoPkg::rgbBlack;
      frameBorder <= videoPkg::rgbBlack;
    end else if (timing.eof) begin // only between frames, no tearing
      frameMode   <= mode;
      frameFg     <= fgColor;
      frameBorder <= borderColor;
    end
  end

  // --------------------------------------------------
  // position tracking
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      xPos    <= '0;
      yPos    <= '0;
      barCnt  <= '0;
      barIdx  <= '0;
      borderQ <= 1'b1;
    end else begin
      borderQ <= timing.border;
      // x and bar state restart outside the display band
      if (timing.eol || timing.border) begin
        xPos   <= '0;
        barCnt <= '0;
        barIdx <= '0;
      end else begin
        xPos <= xPos + 1'b1;
        if (barCnt == barWidth - 1'b1) begin
          barCnt <= '0;
          barIdx <= barIdx + 1'b1; // next bar
        end else begin
          barCnt <= barCnt + 1'b1;
        end
      end
      // y steps when a display band ends, frame end restarts it
      if (timing.eof) begin
        yPos <= '0;
      end else if (!borderQ && timing.border) begin
        yPos <= yPos + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // colour select
  // --------------------------------------------------
  always_comb begin
    nextPixel = videoPkg::rgbBlack;
    if (timing.blank) begin
      nextPixel = videoPkg::rgbBlack;
    end else if (!inDisplay) begin
      nextPixel = frameBorder;
    end else begin
      case (frameMode)
        videoPkg::patSolid: nextPixel = frameFg;
        videoPkg::patBars: begin
          nextPixel.red   = {4{barIdx[2]}};
          nextPixel.green = {4{barIdx[1]}};
          nextPixel.blue  = {4{barIdx[0]}};
        end
        videoPkg::patGrid: begin
          if (((xPos & gridMask) == '0) || ((yPos & gridMask) == '0))
            nextPixel = videoPkg::rgbWhite;
        end
        default: nextPixel = videoPkg::rgbBlack; // unused code
      endcase
    end
  end

  // output stage, pixel and sync stay aligned
  always_ff @(posedge clk) begin
    if (reset) begin
      sync  <= videoPkg::syncIdle;
      pixel <= videoPkg::rgbBlack;
    end else begin
      sync  <= timing;
      pixel <= nextPixel;
    end
  end

endmodule

// ==== src/posCounter.sv ====
// loadable position counter
module posCounter #(
  parameter int width = 12
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,  // count step
  input  logic             load,    // restart at 1, only with enable
  output logic [width-1:0] count
);

  // positions are one based
  localparam logic [width-1:0] one = {{(width - 1){1'b0}}, 1'b1};

  // --------------------------------------------------
  // count register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= one;
    end else if (enable) begin
      if (load) begin
        count <= one;            // wrap at end of line / frame
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // a load without enable is ignored on purpose:
  // the vertical counter only sees eof together with eol

endmodule

// ==== src/syncGen.sv ====
// raster sync generator
module syncGen #(
  // horizontal positions, in pixel clocks
  parameter logic [videoPkg::ctrWidth-1:0] hSyncOn    = 12'd48,
  parameter logic [videoPkg::ctrWidth-1:0] hSyncOff   = 12'd136,
  parameter logic [videoPkg::ctrWidth-1:0] hBlankOff  = 12'd280,
  parameter logic [videoPkg::ctrWidth-1:0] hBorderOff = 12'd284,
  parameter logic [videoPkg::ctrWidth-1:0] hBorderOn  = 12'd1124,
  parameter logic [videoPkg::ctrWidth-1:0] hBlankOn   = 12'd1128,
  parameter logic [videoPkg::ctrWidth-1:0] hTotal     = 12'd1128,
  // vertical positions, in lines
  parameter logic [videoPkg::ctrWidth-1:0] vSyncOn    = 12'd1,
  parameter logic [videoPkg::ctrWidth-1:0] vSyncOff   = 12'd4,
  parameter logic [videoPkg::ctrWidth-1:0] vBlankOff  = 12'd34,
  parameter logic [videoPkg::ctrWidth-1:0] vBorderOff = 12'd36,
  parameter logic [videoPkg::ctrWidth-1:0] vBorderOn  = 12'd1086,
  parameter logic [videoPkg::ctrWidth-1:0] vBlankOn   = 12'd1087,
  parameter logic [videoPkg::ctrWidth-1:0] vTotal     = 12'd1087
) (
  input  logic          clk,
  input  logic          reset,
  output videoPkg::syncT timing  // registered, one cycle behind counters
);

  logic [videoPkg::ctrWidth-1:0] hCtr; // 1..hTotal
  logic [videoPkg::ctrWidth-1:0] vCtr; // 1..vTotal

  logic eolNow;
  logic eofNow;
  logic hSyncNow, vSyncNow;
  logic hBlank, vBlank;
  logic hBorder, vBorder;

  // --------------------------------------------------
  // position counters
  // --------------------------------------------------
  posCounter #(
    .width (videoPkg::ctrWidth)
  ) hCounter (
    .clk    (clk),
    .reset  (reset),
    .enable (1'b1),    // free running
    .load   (eolNow),
    .count  (hCtr)
  );

  posCounter #(
    .width (videoPkg::ctrWidth)
  ) vCounter (
    .clk    (clk),
    .reset  (reset),
    .enable (eolNow),  // one step per line
    .load   (eofNow),
    .count  (vCtr)
  );

  // --------------------------------------------------
  // window decode on current counts
  // --------------------------------------------------
  assign eolNow = (hCtr == hTotal);
  assign eofNow = eolNow && (vCtr == vTotal);

  assign hSyncNow = (hCtr >= hSyncOn) && (hCtr < hSyncOff);
  assign vSyncNow = (vCtr >= vSyncOn) && (vCtr < vSyncOff);

  // blank and border are set outside their windows
  assign hBlank  = (hCtr >= hBlankOn)  || (hCtr < hBlankOff);
  assign vBlank  = (vCtr >= vBlankOn)  || (vCtr < vBlankOff);
  assign hBorder = (hCtr >= hBorderOn) || (hCtr < hBorderOff);
  assign vBorder = (vCtr >= vBorderOn) || (vCtr < vBorderOff);

  // --------------------------------------------------
  // flag register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      timing <= videoPkg::syncIdle;
    end else begin
      timing.hSync  <= ~hSyncNow;          // active low out
      timing.vSync  <= vSyncNow;
      timing.blank  <= hBlank | vBlank;
      timing.border <= hBorder | vBorder;
      timing.eol    <= eolNow;
      timing.eof    <= eofNow;
    end
  end

endmodule

// ==== src/videoPkg.sv ====
// video timing shared types
package videoPkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int ctrWidth = 12; // position count width, 1..total

  // --------------------------------------------------
  // per pixel timing flags
  // --------------------------------------------------
  // all fields describe the same counter position
  typedef struct packed {
    logic hSync;  // active low
    logic vSync;  // active high
    logic blank;  // outside blank window on either axis
    logic border; // outside border window on either axis
    logic eol;    // last pixel of a line
    logic eof;    // last pixel of a frame, always with eol
  } syncT;

  // state right after reset, counters still at 1
  localparam syncT syncIdle = '{
    hSync:  1'b1,
    vSync:  1'b0,
    blank:  1'b1,
    border: 1'b1,
    eol:    1'b0,
    eof:    1'b0
  };

  // --------------------------------------------------
  // colour
  // --------------------------------------------------
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgbT;

  localparam rgbT rgbBlack = '{red: 4'h0, green: 4'h0, blue: 4'h0};
  localparam rgbT rgbWhite = '{red: 4'hf, green: 4'hf, blue: 4'hf};

  // --------------------------------------------------
  // display pattern selection
  // --------------------------------------------------
  typedef enum logic [1:0] {
    patSolid, // whole display in foreground colour
    patBars,  // eight vertical bars
    patGrid   // white lines every 2**gridShift pixels
  } patternE;

endpackage

// ==== src/videoTop.sv ====
// video timing top level
module videoTop #(
  // WXGA horizontal, 840 wide display
  parameter logic [videoPkg::ctrWidth-1:0] hSyncOn    = 12'd48,   // front porch
  parameter logic [videoPkg::ctrWidth-1:0] hSyncOff   = 12'd136,  // sync width 88
  parameter logic [videoPkg::ctrWidth-1:0] hBlankOff  = 12'd280,  // back porch
  parameter logic [videoPkg::ctrWidth-1:0] hBorderOff = 12'd284,
  parameter logic [videoPkg::ctrWidth-1:0] hBorderOn  = 12'd1124,
  parameter logic [videoPkg::ctrWidth-1:0] hBlankOn   = 12'd1128,
  parameter logic [videoPkg::ctrWidth-1:0] hTotal     = 12'd1128,
  // WXGA vertical, 1050 lines
  parameter logic [videoPkg::ctrWidth-1:0] vSyncOn    = 12'd1,
  parameter logic [videoPkg::ctrWidth-1:0] vSyncOff   = 12'd4,
  parameter logic [videoPkg::ctrWidth-1:0] vBlankOff  = 12'd34,
  parameter logic [videoPkg::ctrWidth-1:0] vBorderOff = 12'd36,
  parameter logic [videoPkg::ctrWidth-1:0] vBorderOn  = 12'd1086,
  parameter logic [videoPkg::ctrWidth-1:0] vBlankOn   = 12'd1087,
  parameter logic [videoPkg::ctrWidth-1:0] vTotal     = 12'd1087,
  // pattern geometry, 8 bars fill the display
  parameter logic [videoPkg::ctrWidth-1:0] barWidth   = 12'd105,
  parameter int                            gridShift  = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  videoPkg::patternE mode,
  input  videoPkg::rgbT     fgColor,
  input  videoPkg::rgbT     borderColor,
  output videoPkg::syncT    sync,   // two cycles behind counters
  output videoPkg::rgbT     pixel
);

  videoPkg::syncT timing; // syncGen to patternGen

  syncGen #(
    .hSyncOn (hSyncOn), .hSyncOff (hSyncOff), .hBlankOff (hBlankOff),
    .hBorderOff (hBorderOff), .hBorderOn (hBorderOn), .hBlankOn (hBlankOn),
    .hTotal (hTotal),
    .vSyncOn (vSyncOn), .vSyncOff (vSyncOff), .vBlankOff (vBlankOff),
    .vBorderOff (vBorderOff), .vBorderOn (vBorderOn), .vBlankOn (vBlankOn),
    .vTotal (vTotal)
  ) syncGen (
    .clk    (clk),
    .reset  (reset),
    .timing (timing)
  );

  patternGen #(
    .barWidth  (barWidth),
    .gridShift (gridShift)
  ) patternGen (
    .clk         (clk),
    .reset       (reset),
    .timing      (timing),
    .mode        (mode),
    .fgColor     (fgColor),
    .borderColor (borderColor),
    .sync        (sync),
    .pixel       (pixel)
  );

endmodule
